// ==== include/div_consts.svh ====
// Sizing constants for the integer divide unit
// Data width, instruction id count and width, input FIFO depth

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

////////////////////////////////////////
// Datapath

// Operand and result width
`define DIV_XLEN 32

////////////////////////////////////////
// Instruction tracking

// Number of ids in flight, also the result bank size
`define DIV_MAX_INFLIGHT 4
// Id width, log2 of the in-flight count
`define DIV_ID_W 2

// Input buffer entries, kept below the in-flight count
`define DIV_FIFO_DEPTH 2

`endif

// ==== source/div_pkg.sv ====
// Shared types of the divide unit
// Opcode enum, issued request, buffered unit inputs, core FSM states

`default_nettype none

`include "div_consts.svh"

package div_pkg;

    ////////////////////////////////////////
    // Opcodes

    // Bit 0 selects unsigned, bit 1 selects remainder
    typedef enum logic [1:0] {
        DIV_OP_DIV  = 2'd0,
        DIV_OP_DIVU = 2'd1,
        DIV_OP_REM  = 2'd2,
        DIV_OP_REMU = 2'd3
    } div_op_e;

    ////////////////////////////////////////
    // Request formats

    // Request as issued by the pipeline
    typedef struct packed {
        div_op_e                   op;
        logic [`DIV_XLEN-1:0]      rs1;
        logic [`DIV_XLEN-1:0]      rs2;
        logic [`DIV_ID_W-1:0]      id;
    } div_request_t;

    // Request plus reuse flag and decoded id, one FIFO entry
    typedef struct packed {
        div_op_e                   op;
        logic [`DIV_XLEN-1:0]      rs1;
        logic [`DIV_XLEN-1:0]      rs2;
        logic [`DIV_ID_W-1:0]      id;
        logic                      reuse_result;
        logic [`DIV_MAX_INFLIGHT-1:0] id_one_hot;
    } div_inputs_t;

    ////////////////////////////////////////
    // Core FSM
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } div_core_state_e;

endpackage

`default_nettype wire

// ==== source/div_input_fifo.sv ====
// In-order request buffer of the divide unit
// Register array with read/write pointers and an occupancy count
// Head entry visible without a pop, simultaneous push and pop allowed

`default_nettype none

`include "div_consts.svh"

module div_input_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  div_pkg::div_inputs_t data_in,
    input  logic               pop,
    output div_pkg::div_inputs_t data_out,
    output logic               valid,
    output logic               full
);

    localparam int DEPTH = `DIV_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    div_pkg::div_inputs_t entries [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    ////////////////////////////////////////
    // Storage

    // Payload only, no reset needed
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    assign data_out = entries[rd_ptr];

    ////////////////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap at depth, depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Push with pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign valid = (count != '0);
    assign full  = (count == FULL_CNT);

    ////////////////////////////////////////
    // Checks

    // Caller must honour ready, head must exist before completion
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full input FIFO");
    assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else $error("pop from empty input FIFO");

endmodule

`default_nettype wire

// ==== source/div_core.sv ====
// Iterative unsigned divider core
// Restoring shift-subtract, one quotient bit per cycle
// IDLE/RUN/HOLD FSM with bit counter, results held until next start

`default_nettype none

`include "div_consts.svh"

module div_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic [`DIV_XLEN-1:0] quotient,
    output logic [`DIV_XLEN-1:0] remainder,
    output logic                 complete,
    output logic                 divisor_zero
);

    localparam int XLEN  = `DIV_XLEN;
    localparam int CNT_W = $clog2(XLEN);

    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(XLEN - 1);

    div_pkg::div_core_state_e state;

    logic [CNT_W-1:0] bit_count;
    logic [XLEN-1:0]  q_reg;
    logic [XLEN-1:0]  r_reg;
    logic [XLEN-1:0]  d_reg;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    trial;
    logic             load;

    // Loading in RUN would corrupt the running division
    assign load = start && (state != div_pkg::RUN);

    ////////////////////////////////////////
    // Iteration step

    // Next dividend bit enters the partial remainder
    assign shifted = {r_reg, q_reg[XLEN-1]};
    // Sign bit of trial set means divisor did not fit
    assign trial   = shifted - {1'b0, d_reg};

    ////////////////////////////////////////
    // FSM and counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= div_pkg::IDLE;
            bit_count <= '0;
            complete  <= 1'b0;
        end else begin
            complete <= 1'b0;
            case (state)
                div_pkg::RUN: begin
                    bit_count <= bit_count + 1'b1;
                    if (bit_count == LAST_BIT) begin
                        state    <= div_pkg::HOLD;
                        complete <= 1'b1;
                    end
                end
                default: begin
                    // IDLE and HOLD both accept a new start
                    if (load) begin
                        state     <= div_pkg::RUN;
                        bit_count <= '0;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Datapath

    // Quotient shifts in where the dividend shifts out
    // Zero divisor always fits, giving all ones and the dividend
    always_ff @(posedge clk) begin
        if (load) begin
            q_reg        <= dividend;
            r_reg        <= '0;
            d_reg        <= divisor;
            divisor_zero <= (divisor == '0);
        end else if (state == div_pkg::RUN) begin
            if (trial[XLEN]) begin
                r_reg <= shifted[XLEN-1:0];
                q_reg <= {q_reg[XLEN-2:0], 1'b0};
            end else begin
                r_reg <= trial[XLEN-1:0];
                q_reg <= {q_reg[XLEN-2:0], 1'b1};
            end
        end
    end

    assign quotient  = q_reg;
    assign remainder = r_reg;

    // Control must wait for complete before starting again
    assert property (@(posedge clk) disable iff (rst) start |-> state != div_pkg::RUN)
        else $error("divider started while running");

endmodule

`default_nettype wire

// ==== source/div_reuse_detect.sv ====
// Result reuse detection for back-to-back divides
// Records the last accepted operands and signedness
// Flags a request whose results the core already holds, decodes id to one-hot

`default_nettype none

`include "div_consts.svh"

module div_reuse_detect (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_new_request,
    input  div_pkg::div_request_t issue_request,
    output div_pkg::div_inputs_t unit_inputs
);

    localparam int XLEN     = `DIV_XLEN;
    localparam int INFLIGHT = `DIV_MAX_INFLIGHT;

    logic [XLEN-1:0] last_rs1;
    logic [XLEN-1:0] last_rs2;
    logic            last_unsigned;
    logic            have_last;
    logic            operands_match;

    ////////////////////////////////////////
    // Last accepted request

    // Nothing held by the core until the first request
    always_ff @(posedge clk) begin
        if (rst) begin
            have_last <= 1'b0;
        end else if (issue_new_request) begin
            have_last <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_new_request) begin
            last_rs1      <= issue_request.rs1;
            last_rs2      <= issue_request.rs2;
            last_unsigned <= issue_request.op[0];
        end
    end

    ////////////////////////////////////////
    // Match and unit inputs

    // Signedness changes the magnitudes the core divided
    assign operands_match = (issue_request.rs1 == last_rs1) &&
                            (issue_request.rs2 == last_rs2) &&
                            (issue_request.op[0] == last_unsigned);

    always_comb begin
        unit_inputs.op           = issue_request.op;
        unit_inputs.rs1          = issue_request.rs1;
        unit_inputs.rs2          = issue_request.rs2;
        unit_inputs.id           = issue_request.id;
        unit_inputs.reuse_result = have_last && operands_match;
        // Id decode
        for (int i = 0; i < INFLIGHT; i++) begin
            unit_inputs.id_one_hot[i] = (issue_request.id == i);
        end
    end

endmodule

`default_nettype wire

// ==== source/div_unit.sv ====
// Integer divide unit
// Input FIFO, operand sign handling and core control
// Result sign correction, result bank indexed by instruction id

`default_nettype none

`include "div_consts.svh"

module div_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  div_pkg::div_inputs_t         unit_inputs,
    input  logic                         issue_new_request,
    output logic                         issue_ready,
    output logic [`DIV_MAX_INFLIGHT-1:0] done_next_cycle,
    input  logic [`DIV_ID_W-1:0]         writeback_id,
    output logic [`DIV_XLEN-1:0]         rd
);

    localparam int XLEN     = `DIV_XLEN;
    localparam int INFLIGHT = `DIV_MAX_INFLIGHT;

    div_pkg::div_inputs_t head;

    logic            head_valid;
    logic            fifo_full;
    logic            start_core;
    logic            in_progress;
    logic            core_complete;
    logic            div_done;
    logic            divisor_zero;
    logic            signed_op;
    logic            dividend_neg;
    logic            divisor_neg;
    logic            quotient_neg;
    logic            remainder_neg;
    logic            negate_result;
    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic [XLEN-1:0] raw_result;
    logic [XLEN-1:0] final_result;
    logic [XLEN-1:0] rd_bank [INFLIGHT];

    ////////////////////////////////////////
    // Input buffering
    div_input_fifo input_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (issue_new_request),
        .data_in  (unit_inputs),
        .pop      (div_done),
        .data_out (head),
        .valid    (head_valid),
        .full     (fifo_full)
    );

    assign issue_ready = ~fifo_full;

    ////////////////////////////////////////
    // Core control

    // Reuse heads finish at once, others wait for the core
    assign start_core = head_valid && !in_progress && !head.reuse_result;
    assign div_done   = core_complete || (head_valid && head.reuse_result);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_progress <= 1'b0;
        end else if (start_core) begin
            in_progress <= 1'b1;
        end else if (core_complete) begin
            in_progress <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Sign handling
    assign signed_op     = ~head.op[0];
    assign dividend_neg  = signed_op & head.rs1[XLEN-1];
    assign divisor_neg   = signed_op & head.rs2[XLEN-1];
    // Remainder follows the dividend
    assign quotient_neg  = signed_op & (head.rs1[XLEN-1] ^ head.rs2[XLEN-1]);
    assign remainder_neg = dividend_neg;

    // Magnitudes for the unsigned core
    assign dividend_mag = ({XLEN{dividend_neg}} ^ head.rs1) + XLEN'(dividend_neg);
    assign divisor_mag  = ({XLEN{divisor_neg}} ^ head.rs2) + XLEN'(divisor_neg);

    div_core core_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start_core),
        .dividend     (dividend_mag),
        .divisor      (divisor_mag),
        .quotient     (quotient),
        .remainder    (remainder),
        .complete     (core_complete),
        .divisor_zero (divisor_zero)
    );

    ////////////////////////////////////////
    // Result correction

    // Quotient of a zero divide stays all ones
    assign negate_result = head.op[1] ? remainder_neg : (~divisor_zero & quotient_neg);
    assign raw_result    = head.op[1] ? remainder : quotient;
    assign final_result  = ({XLEN{negate_result}} ^ raw_result) + XLEN'(negate_result);

    ////////////////////////////////////////
    // Result bank
    always_ff @(posedge clk) begin
        if (div_done) begin
            rd_bank[head.id] <= final_result;
        end
    end

    assign done_next_cycle = head.id_one_hot & {INFLIGHT{div_done}};
    assign rd              = rd_bank[writeback_id];

    // Single completion per cycle, core only completes work it was given
    assert property (@(posedge clk) disable iff (rst) $onehot0(done_next_cycle))
        else $error("more than one done bit set");
    assert property (@(posedge clk) disable iff (rst) core_complete |-> in_progress)
        else $error("core completed without a computation in progress");

endmodule

`default_nettype wire

// ==== source/div_top.sv ====
// Top level of the divide unit
// Reuse detector feeding the divide unit

`default_nettype none

`include "div_consts.svh"

module div_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue_new_request,
    input  div_pkg::div_request_t        issue_request,
    output logic                         issue_ready,
    output logic [`DIV_MAX_INFLIGHT-1:0] done_next_cycle,
    input  logic [`DIV_ID_W-1:0]         writeback_id,
    output logic [`DIV_XLEN-1:0]         rd
);

    // Request with reuse flag and decoded id
    div_pkg::div_inputs_t unit_inputs;

    ////////////////////////////////////////
    // Reuse detection
    div_reuse_detect reuse_detect_i (
        .clk               (clk),
        .rst               (rst),
        .issue_new_request (issue_new_request),
        .issue_request     (issue_request),
        .unit_inputs       (unit_inputs)
    );

    ////////////////////////////////////////
    // Divide unit
    div_unit unit_i (
        .clk               (clk),
        .rst               (rst),
        .unit_inputs       (unit_inputs),
        .issue_new_request (issue_new_request),
        .issue_ready       (issue_ready),
        .done_next_cycle   (done_next_cycle),
        .writeback_id      (writeback_id),
        .rd                (rd)
    );

endmodule

`default_nettype wire

// ==== tests/tb_div_top.sv ====
// Directed testbench for the divide unit top level
// RISC-V reference model, compare tasks, issue and collect tasks
// Tests for unsigned, signed, corner cases, reuse, back-pressure, bank holding

`default_nettype none

`include "div_consts.svh"

module tb_div_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN           = `DIV_XLEN;
    localparam int INFLIGHT       = `DIV_MAX_INFLIGHT;
    localparam int MAX_REQUESTS   = 60;
    localparam int TIMEOUT_CYCLES = MAX_REQUESTS * 40 + 200;
    localparam int DONE_WAIT      = 120;
    localparam int BURST          = 32;
    // From the request cycle: one cycle to the head, then load plus XLEN iterations
    localparam int COMPUTE_LATENCY = XLEN + 2;
    localparam int REUSE_LATENCY   = 1;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    // One expected completion
    typedef struct packed {
        div_pkg::div_op_e     op;
        logic [`DIV_ID_W-1:0] id;
        logic [XLEN-1:0]      value;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  issue_new_request;
    div_pkg::div_request_t issue_request;
    logic                  issue_ready;
    logic [INFLIGHT-1:0]   done_next_cycle;
    logic [`DIV_ID_W-1:0]  writeback_id;
    logic [XLEN-1:0]       rd;

    div_pkg::div_request_t send_q[$];
    expect_t               expect_q[$];
    expect_t               bank_model [INFLIGHT];
    logic [`DIV_ID_W-1:0]  next_id;
    string                 test_name;
    int                    cycle_count;
    int                    check_count;
    int                    error_count;
    int                    issue_cycle;
    int                    done_cycle;
    int                    stall_cycles;

    div_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .issue_new_request (issue_new_request),
        .issue_request     (issue_request),
        .issue_ready       (issue_ready),
        .done_next_cycle   (done_next_cycle),
        .writeback_id      (writeback_id),
        .rd                (rd)
    );

    ////////////////////////////////////////
    // Clock and run limit
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model

    // Zero divisor and MOST_NEG / -1 follow the ISA rules
    function automatic logic [XLEN-1:0] reference_result(div_pkg::div_op_e op,
                                                         logic [XLEN-1:0] a,
                                                         logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0] q;
        logic [XLEN-1:0] r;
        logic            is_unsigned;
        logic            is_rem;
        sa = a;
        sb = b;
        is_unsigned = (op == div_pkg::DIV_OP_DIVU) || (op == div_pkg::DIV_OP_REMU);
        is_rem      = (op == div_pkg::DIV_OP_REM) || (op == div_pkg::DIV_OP_REMU);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (!is_unsigned && a == MOST_NEG && b == '1) begin
            q = a;
            r = '0;
        end else if (is_unsigned) begin
            q = a / b;
            r = a % b;
        end else begin
            // Signed remainder takes the dividend's sign
            q = sa / sb;
            r = sa % sb;
        end
        return is_rem ? r : q;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    task automatic check_result(string name, div_pkg::div_op_e op,
                                logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s %s: expected %h actual %h", name, op.name(), expected, actual);
        end
    endtask

    task automatic check_done(string name, logic [INFLIGHT-1:0] expected,
                              logic [INFLIGHT-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s done vector: expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_latency(string name, int expected, int actual);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("Mismatch %s latency: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Request traffic

    // Ids cycle 0..3 in issue order
    task automatic queue_request(div_pkg::div_op_e op, logic [XLEN-1:0] a,
                                 logic [XLEN-1:0] b);
        div_pkg::div_request_t req;
        expect_t               exp;
        req.op    = op;
        req.rs1   = a;
        req.rs2   = b;
        req.id    = next_id;
        exp.op    = op;
        exp.id    = next_id;
        exp.value = reference_result(op, a, b);
        send_q.push_back(req);
        expect_q.push_back(exp);
        bank_model[next_id] = exp;
        next_id++;
    endtask

    // Ready checked with the previous cycle idle, so it still holds when driven
    task automatic issue_one(div_pkg::div_request_t req);
        @(negedge clk);
        while (!issue_ready) begin
            stall_cycles++;
            @(negedge clk);
        end
        issue_cycle = cycle_count + 1;
        @(posedge clk);
        issue_new_request <= 1'b1;
        issue_request     <= req;
        @(posedge clk);
        issue_new_request <= 1'b0;
    endtask

    // Done sampled mid-cycle, bank read back in the following cycle
    task automatic collect_results(int total);
        expect_t             exp;
        expect_t             pending;
        logic                have_pending;
        logic [INFLIGHT-1:0] expected_vec;
        int                  collected;
        int                  idle;
        have_pending = 1'b0;
        collected    = 0;
        idle         = 0;
        while (collected < total || have_pending) begin
            @(negedge clk);
            if (have_pending) begin
                check_result(test_name, pending.op, pending.value, rd);
                have_pending = 1'b0;
            end
            if (done_next_cycle != '0) begin
                idle = 0;
                if (expect_q.size() == 0) begin
                    error_count++;
                    $display("done pulse with no request outstanding in %s", test_name);
                end else begin
                    exp = expect_q.pop_front();
                    expected_vec = '0;
                    expected_vec[exp.id] = 1'b1;
                    check_done(test_name, expected_vec, done_next_cycle);
                    pending      = exp;
                    have_pending = 1'b1;
                    done_cycle   = cycle_count;
                    collected++;
                    @(posedge clk);
                    writeback_id <= exp.id;
                end
            end else if (collected < total) begin
                idle++;
                if (idle > DONE_WAIT) begin
                    error_count++;
                    $display("done pulse never arrived in %s", test_name);
                    expect_q.delete();
                    collected = total;
                end
            end
        end
    endtask

    task automatic run_requests();
        int total;
        total = send_q.size();
        fork
            begin
                while (send_q.size() > 0) begin
                    issue_one(send_q.pop_front());
                end
            end
            collect_results(total);
        join
    endtask

    task automatic read_bank();
        for (int i = 0; i < INFLIGHT; i++) begin
            @(posedge clk);
            writeback_id <= `DIV_ID_W'(i);
            @(negedge clk);
            check_result(test_name, bank_model[i].op, bank_model[i].value, rd);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    task automatic test_reset_unsigned();
        test_name = "reset_unsigned";
        @(negedge clk);
        check_done(test_name, '0, done_next_cycle);
        check_count++;
        if (issue_ready !== 1'b1) begin
            error_count++;
            $display("issue_ready is not high after reset");
        end
        queue_request(div_pkg::DIV_OP_DIVU, 32'd100, 32'd7);
        queue_request(div_pkg::DIV_OP_REMU, 32'd100, 32'd7);
        queue_request(div_pkg::DIV_OP_DIVU, 32'hffff_ffff, 32'd3);
        queue_request(div_pkg::DIV_OP_REMU, 32'hffff_fff0, 32'd7);
        run_requests();
    endtask

    // All four sign combinations, DIV then REM of each
    task automatic test_signed();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        test_name = "signed";
        for (int s = 0; s < 4; s++) begin
            a = XLEN'(1000);
            b = XLEN'(37);
            if (s[0]) a = -a;
            if (s[1]) b = -b;
            queue_request(div_pkg::DIV_OP_DIV, a, b);
            queue_request(div_pkg::DIV_OP_REM, a, b);
        end
        run_requests();
    endtask

    task automatic test_corners();
        test_name = "corners";
        queue_request(div_pkg::DIV_OP_DIV, 32'h8000_0007, '0);
        queue_request(div_pkg::DIV_OP_DIVU, 32'h8000_0007, '0);
        queue_request(div_pkg::DIV_OP_REM, 32'h8000_0007, '0);
        queue_request(div_pkg::DIV_OP_REMU, 32'h8000_0007, '0);
        // Signed overflow
        queue_request(div_pkg::DIV_OP_DIV, MOST_NEG, '1);
        queue_request(div_pkg::DIV_OP_REM, MOST_NEG, '1);
        run_requests();
    endtask

    // One at a time so latency shows whether the core ran
    task automatic test_reuse();
        test_name = "reuse";
        queue_request(div_pkg::DIV_OP_DIV, 32'hf000_1234, 32'h0000_0123);
        run_requests();
        check_latency("reuse DIV", COMPUTE_LATENCY, done_cycle - issue_cycle);
        queue_request(div_pkg::DIV_OP_REM, 32'hf000_1234, 32'h0000_0123);
        run_requests();
        check_latency("reuse REM", REUSE_LATENCY, done_cycle - issue_cycle);
        // Same bits, other signedness
        queue_request(div_pkg::DIV_OP_DIVU, 32'hf000_1234, 32'h0000_0123);
        run_requests();
        check_latency("reuse DIVU", COMPUTE_LATENCY, done_cycle - issue_cycle);
    endtask

    task automatic test_burst();
        div_pkg::div_op_e op;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        test_name    = "burst";
        stall_cycles = 0;
        for (int i = 0; i < BURST; i++) begin
            op = div_pkg::div_op_e'(2'($urandom_range(0, 3)));
            // Operands kept about a third of the time
            if (i == 0 || $urandom_range(0, 2) != 0) begin
                a = $urandom;
                case ($urandom_range(0, 4))
                    0: b = '0;
                    1: b = XLEN'($urandom_range(1, 15));
                    2: b = '1;
                    default: b = $urandom;
                endcase
            end
            queue_request(op, a, b);
        end
        run_requests();
        check_count++;
        if (stall_cycles == 0) begin
            error_count++;
            $display("issue_ready never dropped during the burst");
        end
    endtask

    // Reissue one id, the other entries must stay put
    task automatic test_bank();
        test_name = "bank_hold";
        read_bank();
        queue_request(div_pkg::DIV_OP_DIV, 32'd12345, 32'd67);
        run_requests();
        read_bank();
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(32'h2e4894f3));
        rst               = 1'b1;
        issue_new_request = 1'b0;
        issue_request     = '0;
        writeback_id      = '0;
        next_id           = '0;
        cycle_count       = 0;
        check_count       = 0;
        error_count       = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset_unsigned();
        test_signed();
        test_corners();
        test_reuse();
        test_burst();
        test_bank();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
source/div_pkg.sv
source/div_input_fifo.sv
source/div_core.sv
source/div_reuse_detect.sv
source/div_unit.sv
source/div_top.sv
tests/tb_div_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the divide unit testbench with Verilator, run it and check the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
pass_msg="Done: no errors"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_div_top -Mdir "$build_dir" -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_div_top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "$pass_msg" "$log_file"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
